/* src.f */
+incdir+hdl
hdl/smp_types_pkg.sv
hdl/smp_bus_pkg.sv
hdl/sample_capture.sv
hdl/sample_dpram.sv
hdl/bus_bridge.sv
hdl/sample_playback.sv
hdl/sample_buffer_top.sv
sim/tb_sample_buffer.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the sample buffer testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_sample_buffer \
    -f src.f -o sim_tb

status=0
./obj_dir/sim_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Something failed" sim.log; then
    echo "Simulation reported a failure (exit status ${status})"
    exit 1
fi

echo "Simulation finished without a reported failure"
exit 0

/* sim/tb_sample_buffer.sv */
`default_nettype none

module tb_sample_buffer;

    timeunit 1ns;
    timeprecision 100ps;

    import smp_types_pkg::*;
    import smp_bus_pkg::*;

    localparam int n_stream = 64;
    localparam int n_host   = 12;
    localparam int n_part   = 4;
    localparam int n_play   = 40;
    // Reset, stream and playback, host pairs, drop test, stolen playback, margin
    localparam int cycle_limit = 8 + 2 * n_stream + 5 * (n_host + n_part) + 8
                               + 3 * n_play + 100;

    logic      clk_i = 1'b0;
    logic      rst_ni;
    logic      sample_valid_i;
    sample_t   sample_i;
    logic      play_en_i;
    logic      sample_valid_o;
    sample_t   sample_o;
    logic      bus_req_i;
    logic      bus_we_i;
    addr_t     bus_addr_i;
    bus_data_t bus_wdata_i;
    bus_be_t   bus_be_i;
    logic      bus_rvalid_o;
    bus_data_t bus_rdata_o;
    addr_t     wptr_o;
    cnt_t      drop_cnt_o;

    // Reference model state
    sample_t   m_mem [1024];
    bus_data_t m_hold;
    addr_t     m_waddr;
    logic      m_commit;  // Port A belongs to the host this cycle
    addr_t     m_wptr;
    cnt_t      m_drop;
    logic      m_pb_valid;
    sample_t   m_pb_data;
    logic      m_rvalid;
    bus_data_t m_rdata;
    sample_t   exp_q [$];  // Accepted samples in playback order
    addr_t     host_addrs [$];

    string       test_name = "reset";
    logic [31:0] lcg_state = 32'd87819;
    int          cycle_cnt = 0;
    int          seen_cnt  = 0;

    sample_buffer_top dut0 (.*);

    always #4 clk_i = ~clk_i;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic stop_with_error(input string msg);
        $display("Something failed");
        $display("%s", msg);
        $fatal(1);
    endtask

    task automatic fail_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        stop_with_error($sformatf("mismatch test %s %s expected %h actual %h",
                                  test_name, what, exp, act));
    endtask

    // Model follows the DUT inputs as they stand at each edge
    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            m_hold     <= '0;
            m_commit   <= 1'b0;
            m_wptr     <= '0;
            m_drop     <= '0;
            m_pb_valid <= 1'b0;
            m_rvalid   <= 1'b0;
            exp_q.delete();
        end else begin
            m_commit <= bus_req_i && bus_we_i;
            if (bus_req_i && bus_we_i) begin
                for (int b = 0; b < 4; b++) begin
                    if (bus_be_i[b]) m_hold[8*b +: 8] <= bus_wdata_i[8*b +: 8];
                end
                m_waddr <= bus_addr_i;
            end
            if (m_commit) m_mem[m_waddr] <= m_hold[15:0];
            m_rvalid <= bus_req_i && !bus_we_i;
            if (bus_req_i && !bus_we_i) m_rdata <= {16'h0, m_mem[bus_addr_i]};  // Old data
            m_pb_valid <= play_en_i && !(bus_req_i && !bus_we_i);
            if (play_en_i && !(bus_req_i && !bus_we_i)) begin
                if (exp_q.size() == 0) stop_with_error("playback read past the captured samples");
                else m_pb_data <= exp_q.pop_front();
            end
            if (sample_valid_i && m_commit) begin
                m_drop <= m_drop + 1'b1;
            end else if (sample_valid_i) begin
                m_mem[m_wptr] <= sample_i;
                m_wptr <= m_wptr + 1'b1;
                exp_q.push_back(sample_i);
            end
        end
    end

    always @(posedge clk_i) begin
        if (rst_ni && sample_valid_o) seen_cnt <= seen_cnt + 1;
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) stop_with_error("timeout, run did not finish in time");
    end

    a_wptr: assert property (@(posedge clk_i) disable iff (!rst_ni) wptr_o == m_wptr)
        else fail_value("wptr_o", 32'($sampled(m_wptr)), 32'($sampled(wptr_o)));
    a_drop: assert property (@(posedge clk_i) disable iff (!rst_ni) drop_cnt_o == m_drop)
        else fail_value("drop_cnt_o", 32'($sampled(m_drop)), 32'($sampled(drop_cnt_o)));
    a_pb_valid: assert property (
        @(posedge clk_i) disable iff (!rst_ni) sample_valid_o == m_pb_valid)
        else fail_value("sample_valid_o", 32'($sampled(m_pb_valid)),
                        32'($sampled(sample_valid_o)));
    a_pb_data: assert property (
        @(posedge clk_i) disable iff (!rst_ni) m_pb_valid |-> sample_o == m_pb_data)
        else fail_value("sample_o", 32'($sampled(m_pb_data)), 32'($sampled(sample_o)));
    a_rvalid_seen: assert property (
        @(posedge clk_i) disable iff (!rst_ni) m_rvalid |-> bus_rvalid_o)
        else stop_with_error("no read response one cycle after the host read request");
    a_rvalid_extra: assert property (
        @(posedge clk_i) disable iff (!rst_ni) !m_rvalid |-> !bus_rvalid_o)
        else stop_with_error("read response without a host read request");
    a_rdata: assert property (
        @(posedge clk_i) disable iff (!rst_ni) m_rvalid |-> bus_rdata_o == m_rdata)
        else fail_value("bus_rdata_o", $sampled(m_rdata), $sampled(bus_rdata_o));

    // All stimulus tasks start and end 1 ns after a rising edge
    task automatic push_sample(input sample_t s);
        sample_valid_i = 1'b1;
        sample_i       = s;
        @(posedge clk_i); #1;
        sample_valid_i = 1'b0;
    endtask

    task automatic host_write(input addr_t a, input bus_data_t d, input bus_be_t be,
                              input bit with_sample, input sample_t s);
        bus_req_i   = 1'b1;
        bus_we_i    = 1'b1;
        bus_addr_i  = a;
        bus_wdata_i = d;
        bus_be_i    = be;
        @(posedge clk_i); #1;
        bus_req_i      = 1'b0;
        bus_we_i       = 1'b0;
        sample_valid_i = with_sample;  // Lands on the commit cycle
        sample_i       = s;
        @(posedge clk_i); #1;
        sample_valid_i = 1'b0;
    endtask

    task automatic host_read(input addr_t a);
        bus_req_i  = 1'b1;
        bus_we_i   = 1'b0;
        bus_addr_i = a;
        @(posedge clk_i); #1;
        bus_req_i = 1'b0;
        while (!bus_rvalid_o) begin
            @(posedge clk_i); #1;
        end
        @(posedge clk_i); #1;
    endtask

    // Plays out every queued sample and optionally steals port B now and then
    task automatic play_all(input bit steal);
        int start;
        int n;
        int cyc;
        start     = seen_cnt;
        n         = exp_q.size();
        cyc       = 0;
        play_en_i = 1'b1;
        while (exp_q.size() > 0) begin
            if (steal && (cyc % 4 == 1)) begin
                bus_req_i  = 1'b1;
                bus_we_i   = 1'b0;
                bus_addr_i = host_addrs[next_rand() % host_addrs.size()];
            end
            @(posedge clk_i); #1;
            bus_req_i = 1'b0;
            cyc++;
        end
        play_en_i = 1'b0;
        while (seen_cnt < start + n) begin
            @(posedge clk_i); #1;
        end
    endtask

    initial begin
        logic [31:0] r;
        addr_t       a;
        rst_ni         = 1'b0;
        sample_valid_i = 1'b0;
        sample_i       = '0;
        play_en_i      = 1'b0;
        bus_req_i      = 1'b0;
        bus_we_i       = 1'b0;
        bus_addr_i     = '0;
        bus_wdata_i    = '0;
        bus_be_i       = '0;
        repeat (8) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        @(posedge clk_i); #1;

        test_name = "stream";
        for (int i = 0; i < n_stream; i++) begin
            r = next_rand();
            push_sample(r[15:0]);
        end
        play_all(1'b0);

        // Host traffic stays in the upper half away from captured samples
        test_name = "host_full";
        for (int i = 0; i < n_host; i++) begin
            r = next_rand();
            a = {1'b1, r[8:0]};
            host_write(a, next_rand(), 4'b1111, 1'b0, '0);
            host_addrs.push_back(a);
            host_read(a);
        end

        test_name = "host_partial";
        for (int i = 0; i < n_part; i++) begin
            a = host_addrs[i];
            host_write(a, next_rand(), (i % 2 == 1) ? 4'b0010 : 4'b0001, 1'b0, '0);
            host_read(a);
        end

        test_name = "drop";
        r = next_rand();
        push_sample(r[15:0]);
        r = next_rand();
        host_write(host_addrs[0], r, 4'b1111, 1'b1, r[31:16]);
        r = next_rand();
        push_sample(r[15:0]);

        test_name = "steal";
        for (int i = 0; i < n_play; i++) begin
            r = next_rand();
            push_sample(r[15:0]);
        end
        play_all(1'b1);
        @(posedge clk_i); #1;

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/sample_buffer_top.sv */
`default_nettype none

module sample_buffer_top (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   sample_valid_i,
    input  smp_types_pkg::sample_t sample_i,
    input  logic                   play_en_i,
    output logic                   sample_valid_o,
    output smp_types_pkg::sample_t sample_o,
    input  logic                   bus_req_i,
    input  logic                   bus_we_i,
    input  smp_types_pkg::addr_t   bus_addr_i,
    input  smp_bus_pkg::bus_data_t bus_wdata_i,
    input  smp_bus_pkg::bus_be_t   bus_be_i,
    output logic                   bus_rvalid_o,
    output smp_bus_pkg::bus_data_t bus_rdata_o,
    output smp_types_pkg::addr_t   wptr_o,
    output smp_types_pkg::cnt_t    drop_cnt_o
);

    import smp_types_pkg::*;

    logic    host_wr;
    addr_t   host_waddr;
    sample_t host_wdata;
    logic    host_rd;
    addr_t   host_raddr;
    logic    cap_we;
    addr_t   cap_addr;
    sample_t cap_data;
    logic    pb_re;
    addr_t   pb_addr;
    logic    a_we;
    addr_t   a_addr;
    sample_t a_data;
    logic    b_re;
    addr_t   b_addr;
    sample_t rd_data;

    sample_capture capture0 (
        .clk_i, .rst_ni, .sample_valid_i, .sample_i,
        .porta_busy_i (host_wr),
        .cap_we_o     (cap_we),
        .cap_addr_o   (cap_addr),
        .cap_data_o   (cap_data),
        .wptr_o, .drop_cnt_o
    );

    bus_bridge bridge0 (
        .clk_i, .rst_ni, .bus_req_i, .bus_we_i, .bus_addr_i, .bus_wdata_i, .bus_be_i,
        .rd_data_i    (rd_data),
        .host_wr_o    (host_wr),
        .host_waddr_o (host_waddr),
        .host_wdata_o (host_wdata),
        .host_rd_o    (host_rd),
        .host_raddr_o (host_raddr),
        .bus_rvalid_o, .bus_rdata_o
    );

    // Host first on both ports, the other side backs off when busy
    assign a_we   = host_wr || cap_we;
    assign a_addr = host_wr ? host_waddr : cap_addr;
    assign a_data = host_wr ? host_wdata : cap_data;
    assign b_re   = host_rd || pb_re;
    assign b_addr = host_rd ? host_raddr : pb_addr;

    sample_dpram ram0 (
        .clk_i,
        .a_we_i (a_we), .a_addr_i (a_addr), .a_data_i (a_data),
        .b_re_i (b_re), .b_addr_i (b_addr), .b_data_o (rd_data)
    );

    sample_playback playback0 (
        .clk_i, .rst_ni, .play_en_i,
        .portb_busy_i (host_rd),
        .pb_re_o      (pb_re),
        .pb_addr_o    (pb_addr),
        .rd_data_i    (rd_data),
        .sample_valid_o, .sample_o
    );

endmodule

`default_nettype wire

/* hdl/sample_playback.sv */
`default_nettype none

module sample_playback (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   play_en_i,
    input  logic                   portb_busy_i,  // Host read owns port B
    output logic                   pb_re_o,
    output smp_types_pkg::addr_t   pb_addr_o,
    input  smp_types_pkg::sample_t rd_data_i,
    output logic                   sample_valid_o,
    output smp_types_pkg::sample_t sample_o
);

    import smp_types_pkg::*;

    addr_t rptr_q;
    logic  valid_q;

    // Read only in free cycles and retry the same address later
    assign pb_re_o   = play_en_i && !portb_busy_i;
    assign pb_addr_o = rptr_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rptr_q <= '0;
        end else if (pb_re_o) begin
            rptr_q <= rptr_q + 1'b1;  // Wraps like the write pointer
        end
    end

    // RAM output is registered, so valid trails the read by one cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= pb_re_o;
        end
    end

    assign sample_valid_o = valid_q;
    assign sample_o       = rd_data_i;

    a_no_read_while_busy: assert property (
        @(posedge clk_i) disable iff (!rst_ni) portb_busy_i |-> !pb_re_o);

endmodule

`default_nettype wire

/* hdl/bus_bridge.sv */
`default_nettype none

module bus_bridge (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    bus_req_i,
    input  logic                    bus_we_i,
    input  smp_types_pkg::addr_t    bus_addr_i,
    input  smp_bus_pkg::bus_data_t  bus_wdata_i,
    input  smp_bus_pkg::bus_be_t    bus_be_i,
    input  smp_types_pkg::sample_t  rd_data_i,
    output logic                    host_wr_o,
    output smp_types_pkg::addr_t    host_waddr_o,
    output smp_types_pkg::sample_t  host_wdata_o,
    output logic                    host_rd_o,
    output smp_types_pkg::addr_t    host_raddr_o,
    output logic                    bus_rvalid_o,
    output smp_bus_pkg::bus_data_t  bus_rdata_o
);

    import smp_types_pkg::*;
    import smp_bus_pkg::*;

    bridge_state_e state_q;
    bridge_state_e state_d;
    bus_data_t     hold_q;
    addr_t         waddr_q;
    logic          wr_req;
    logic          rd_req;

    // Requests are only taken in IDLE
    assign wr_req = bus_req_i && bus_we_i && (state_q == IDLE);
    assign rd_req = bus_req_i && !bus_we_i && (state_q == IDLE);

    always_comb begin
        state_d = IDLE;
        if (wr_req) begin
            state_d = WRITE_COMMIT;
        end else if (rd_req) begin
            state_d = READ_RETURN;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Byte merge where disabled lanes keep older data
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            hold_q <= '0;
        end else if (wr_req) begin
            for (int i = 0; i < $bits(bus_be_t); i++) begin
                if (bus_be_i[i]) begin
                    hold_q[8*i +: 8] <= bus_wdata_i[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_req) begin
            waddr_q <= bus_addr_i;
        end
    end

    assign host_wr_o    = (state_q == WRITE_COMMIT);
    assign host_waddr_o = waddr_q;
    assign host_wdata_o = hold_q[$bits(sample_t)-1:0];  // Low half only
    assign host_rd_o    = rd_req;  // Steals port B this cycle
    assign host_raddr_o = bus_addr_i;
    assign bus_rvalid_o = (state_q == READ_RETURN);
    assign bus_rdata_o  = bus_data_t'(rd_data_i);

    a_req_only_in_idle: assert property (
        @(posedge clk_i) disable iff (!rst_ni) bus_req_i |-> (state_q == IDLE));

    a_rvalid_after_read: assert property (
        @(posedge clk_i) disable iff (!rst_ni) rd_req |=> bus_rvalid_o);

endmodule

`default_nettype wire

/* hdl/sample_dpram.sv */
`default_nettype none

module sample_dpram (
    input  logic                   clk_i,
    input  logic                   a_we_i,
    input  smp_types_pkg::addr_t   a_addr_i,
    input  smp_types_pkg::sample_t a_data_i,
    input  logic                   b_re_i,
    input  smp_types_pkg::addr_t   b_addr_i,
    output smp_types_pkg::sample_t b_data_o
);

    import smp_types_pkg::*;

    localparam int unsigned depth = 1 << $bits(addr_t);

    sample_t mem [depth];

    // Port A, write only
    always_ff @(posedge clk_i) begin
        if (a_we_i) begin
            mem[a_addr_i] <= a_data_i;
        end
    end

    // Port B, registered read
    // Old contents come out when both ports hit the same address
    always_ff @(posedge clk_i) begin
        if (b_re_i) begin
            b_data_o <= mem[b_addr_i];
        end
    end

endmodule

`default_nettype wire

/* hdl/sample_capture.sv */
`default_nettype none

module sample_capture (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   sample_valid_i,
    input  smp_types_pkg::sample_t sample_i,
    input  logic                   porta_busy_i,  // Host commit owns port A
    output logic                   cap_we_o,
    output smp_types_pkg::addr_t   cap_addr_o,
    output smp_types_pkg::sample_t cap_data_o,
    output smp_types_pkg::addr_t   wptr_o,
    output smp_types_pkg::cnt_t    drop_cnt_o
);

    import smp_types_pkg::*;

    addr_t wptr_q;
    cnt_t  drop_q;
    logic  drop;

    // Host has priority and a colliding sample is lost
    assign cap_we_o   = sample_valid_i && !porta_busy_i;
    assign drop       = sample_valid_i && porta_busy_i;
    assign cap_addr_o = wptr_q;
    assign cap_data_o = sample_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wptr_q <= '0;
        end else if (cap_we_o) begin
            wptr_q <= wptr_q + 1'b1;  // Wraps at RAM depth
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            drop_q <= '0;
        end else if (drop && (drop_q != '1)) begin
            drop_q <= drop_q + 1'b1;  // Sticks at max
        end
    end

    assign wptr_o     = wptr_q;
    assign drop_cnt_o = drop_q;

    a_no_write_while_busy: assert property (
        @(posedge clk_i) disable iff (!rst_ni) porta_busy_i |-> !cap_we_o);

endmodule

`default_nettype wire

/* hdl/smp_bus_pkg.sv */
`default_nettype none

`include "smp_cfg.svh"

package smp_bus_pkg;

    typedef logic [`SMP_BUS_W-1:0] bus_data_t;  // Host data word

    // One enable per byte lane of bus_data_t
    typedef logic [`SMP_BUS_W/`SMP_BYTE_W-1:0] bus_be_t;

    // Both non-idle states last exactly one cycle
    typedef enum logic [1:0] {
        IDLE,
        WRITE_COMMIT,  // Holding register goes to port A
        READ_RETURN    // RAM output is valid for the host
    } bridge_state_e;

endpackage

`default_nettype wire

/* hdl/smp_types_pkg.sv */
`default_nettype none

`include "smp_cfg.svh"

package smp_types_pkg;

    // One stream sample as held in RAM
    typedef logic [`SMP_SAMPLE_W-1:0] sample_t;

    // RAM address, also the width of both pointers
    typedef logic [`SMP_ADDR_W-1:0] addr_t;

    typedef logic [15:0] cnt_t;  // Lost-sample counter, saturating

endpackage

`default_nettype wire

/* hdl/smp_cfg.svh */
`ifndef SMP_CFG_SVH
`define SMP_CFG_SVH

// Sample RAM address width, 1024 entries
`define SMP_ADDR_W 10

// Width of one stored sample
`define SMP_SAMPLE_W 16

// Host bus word, split into byte lanes
`define SMP_BUS_W 32

// Byte lane width on the host bus
`define SMP_BYTE_W 8

`endif
